//--- verilog/vfu_cfg_pkg.sv
/*
 * Size constants of the vector functional unit
 * Lane count, lane and register-file word widths, address and id widths
 */

package vfu_cfg_pkg;

  // Lanes and lane word
  localparam int unsigned N_LANES = 2;
  localparam int unsigned ELEN    = 32;
  localparam int unsigned ELENB   = ELEN / 8;

  // One register-file word spans all lanes
  localparam int unsigned VRF_WORD_W     = N_LANES * ELEN;
  localparam int unsigned VRF_BE_W       = VRF_WORD_W / 8;
  localparam int unsigned WORDS_PER_VREG = 4;

  // Register number and word address
  localparam int unsigned VREG_IDX_W  = 5;
  localparam int unsigned VREG_ADDR_W = VREG_IDX_W + $clog2(WORDS_PER_VREG);

  // Vector length in elements, up to 32
  localparam int unsigned VL_W = 6;
  localparam int unsigned ID_W = 2;

endpackage : vfu_cfg_pkg

//--- verilog/vfu_isa_pkg.sv
/*
 * Operation encodings of the vector functional unit
 * Element widths, integer operations, lane word views, pipeline tag
 */

package vfu_isa_pkg;

  // Selected element width
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  // Integer operations of the lanes
  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4
  } vfu_op_e;

  // One lane word, split by element width
  typedef union packed {
    logic [vfu_cfg_pkg::ELENB-1:0][7:0]    b;
    logic [vfu_cfg_pkg::ELENB/2-1:0][15:0] h;
    logic [vfu_cfg_pkg::ELEN-1:0]          w;
  } lane_word_u;

  // Travels with each word from issue to write-back
  typedef struct packed {
    logic [vfu_cfg_pkg::ID_W-1:0]        id;
    logic [vfu_cfg_pkg::VREG_ADDR_W-1:0] vd_addr;
    logic [vfu_cfg_pkg::VRF_BE_W-1:0]    be;
    logic                                last;
  } vfu_tag_t;

endpackage : vfu_isa_pkg

//--- verilog/vfu_if.sv
/*
 * Internal interfaces of the vector functional unit
 * Issue path from sequencer to operand stage, and lane path to write-back
 */

`timescale 1ns/1ps

interface vfu_issue_if;
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  logic            valid;
  vfu_op_e         op;
  vew_e            vsew;
  logic            use_vs1;
  logic [ELEN-1:0] rs1;
  vfu_tag_t        tag;

  modport master (output valid, op, vsew, use_vs1, rs1, tag);
  modport slave  (input  valid, op, vsew, use_vs1, rs1, tag);
endinterface : vfu_issue_if

interface vfu_lane_if;
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  // Operands, one register-file word wide
  logic                  valid;
  vfu_op_e               op;
  vew_e                  vsew;
  logic [VRF_WORD_W-1:0] op1;
  logic [VRF_WORD_W-1:0] op2;
  vfu_tag_t              tag;

  // Results, each lane fills its own slice
  logic [VRF_WORD_W-1:0] result;
  logic [N_LANES-1:0]    res_valid;
  vfu_tag_t              res_tag;

  modport source (output valid, op, vsew, op1, op2, tag);
  modport lane   (input  valid, op, vsew, op1, op2, tag, output result, res_valid, res_tag);
  modport sink   (input  result, res_valid, res_tag);
endinterface : vfu_lane_if

//--- verilog/vfu_op_queue.sv
/*
 * Two-entry request queue in spill-register style
 * Head entry is offered to the sequencer, spill entry catches one more
 */

`timescale 1ns/1ps

module vfu_op_queue (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  logic [vfu_cfg_pkg::ID_W-1:0]           req_id_i,
  input  vfu_isa_pkg::vfu_op_e                   req_op_i,
  input  vfu_isa_pkg::vew_e                      req_vsew_i,
  input  logic [vfu_cfg_pkg::VL_W-1:0]           req_vl_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]     req_vs1_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]     req_vs2_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]     req_vd_i,
  input  logic                                   req_use_vs1_i,
  input  logic [vfu_cfg_pkg::ELEN-1:0]           req_rs1_i,
  output logic                                   deq_valid_o,
  input  logic                                   deq_i,
  output logic [vfu_cfg_pkg::ID_W-1:0]           deq_id_o,
  output vfu_isa_pkg::vfu_op_e                   deq_op_o,
  output vfu_isa_pkg::vew_e                      deq_vsew_o,
  output logic [vfu_cfg_pkg::VL_W-1:0]           deq_vl_o,
  output logic [vfu_cfg_pkg::VREG_IDX_W-1:0]     deq_vs1_o,
  output logic [vfu_cfg_pkg::VREG_IDX_W-1:0]     deq_vs2_o,
  output logic [vfu_cfg_pkg::VREG_IDX_W-1:0]     deq_vd_o,
  output logic                                   deq_use_vs1_o,
  output logic [vfu_cfg_pkg::ELEN-1:0]           deq_rs1_o
);
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  // All request fields in one word, use_vs1 is the extra bit
  logic [ID_W+$bits(vfu_op_e)+$bits(vew_e)+VL_W+3*VREG_IDX_W+ELEN:0] req_in, head_q, spill_q;
  logic [$bits(vfu_op_e)-1:0] head_op;
  logic [$bits(vew_e)-1:0]    head_ew;
  logic                       head_vld_q;
  logic                       spill_vld_q;
  logic                       push;
  logic                       load_head;

  assign req_in = {req_id_i, req_op_i, req_vsew_i, req_vl_i, req_vs1_i, req_vs2_i, req_vd_i,
                   req_use_vs1_i, req_rs1_i};

  assign req_ready_o = !spill_vld_q;
  assign push        = req_valid_i && req_ready_o;
  // Head is free or being popped
  assign load_head   = deq_i || !head_vld_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_vld_q  <= 1'b0;
      spill_vld_q <= 1'b0;
    end else if (load_head) begin
      head_vld_q  <= spill_vld_q || push;
      spill_vld_q <= 1'b0;
    end else if (push) begin
      spill_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_head) begin
      head_q <= spill_vld_q ? spill_q : req_in;
    end else if (push) begin
      spill_q <= req_in;
    end
  end

  assign {deq_id_o, head_op, head_ew, deq_vl_o, deq_vs1_o, deq_vs2_o, deq_vd_o,
          deq_use_vs1_o, deq_rs1_o} = head_q;
  assign deq_op_o    = vfu_op_e'(head_op);
  assign deq_vsew_o  = vew_e'(head_ew);
  assign deq_valid_o = head_vld_q;

endmodule : vfu_op_queue

//--- verilog/vfu_sequencer.sv
/*
 * Word sequencer of the vector functional unit
 * Element counting, register-file addresses, byte enables and tags
 */

`timescale 1ns/1ps

module vfu_sequencer (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     deq_valid_i,
  output logic                                     deq_o,
  input  logic [vfu_cfg_pkg::ID_W-1:0]             deq_id_i,
  input  vfu_isa_pkg::vfu_op_e                     deq_op_i,
  input  vfu_isa_pkg::vew_e                        deq_vsew_i,
  input  logic [vfu_cfg_pkg::VL_W-1:0]             deq_vl_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]       deq_vs1_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]       deq_vs2_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]       deq_vd_i,
  input  logic                                     deq_use_vs1_i,
  input  logic [vfu_cfg_pkg::ELEN-1:0]             deq_rs1_i,
  output logic [1:0][vfu_cfg_pkg::VREG_ADDR_W-1:0] vrf_raddr_o,
  output logic [1:0]                               vrf_re_o,
  vfu_issue_if.master                              issue
);
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  logic [VL_W-1:0]        elem_q;
  logic [VREG_ADDR_W-1:0] word_q;
  logic [3:0]             epw;
  logic [VL_W-1:0]        remaining;
  logic [3:0]             nbytes;
  logic                   last;
  logic [VREG_ADDR_W-1:0] vs1_addr;
  logic [VREG_ADDR_W-1:0] vs2_addr;
  logic [VREG_ADDR_W-1:0] vd_addr;
  logic [VRF_BE_W-1:0]    be;

  ////////////////////////////////////////////////////////////////////////////
  // Current word

  always_comb begin
    // Elements per word: 8, 4 or 2
    epw       = 4'(N_LANES * (ELENB >> deq_vsew_i));
    remaining = deq_vl_i - elem_q;
    last      = remaining <= VL_W'(epw);
    // Partial last word keeps only the bytes of live elements
    nbytes    = 4'((last ? remaining : VL_W'(epw)) << deq_vsew_i);
    be        = ~({VRF_BE_W{1'b1}} << nbytes);
  end

  assign vs2_addr = VREG_ADDR_W'(deq_vs2_i * WORDS_PER_VREG) + word_q;
  assign vs1_addr = VREG_ADDR_W'(deq_vs1_i * WORDS_PER_VREG) + word_q;
  assign vd_addr  = VREG_ADDR_W'(deq_vd_i * WORDS_PER_VREG) + word_q;

  // Pop with the last word, the next head issues right after
  assign deq_o = deq_valid_i && last;

  ////////////////////////////////////////////////////////////////////////////
  // Issue registers

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      elem_q      <= '0;
      word_q      <= '0;
      vrf_re_o    <= '0;
      issue.valid <= 1'b0;
    end else begin
      vrf_re_o    <= deq_valid_i ? {deq_use_vs1_i, 1'b1} : 2'b00;
      issue.valid <= deq_valid_i;
      if (deq_valid_i) begin
        elem_q <= last ? '0 : elem_q + VL_W'(epw);
        word_q <= last ? '0 : word_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (deq_valid_i) begin
      vrf_raddr_o[0] <= vs2_addr;
      vrf_raddr_o[1] <= vs1_addr;
      issue.op       <= deq_op_i;
      issue.vsew     <= deq_vsew_i;
      issue.use_vs1  <= deq_use_vs1_i;
      issue.rs1      <= deq_rs1_i;
      issue.tag      <= '{id: deq_id_i, vd_addr: vd_addr, be: be, last: last};
    end
  end

endmodule : vfu_sequencer

//--- verilog/vfu_operand_stage.sv
/*
 * Operand stage, lines up issue info with register-file read data
 * and replicates the scalar operand to the element width
 */

`timescale 1ns/1ps

module vfu_operand_stage (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic [1:0][vfu_cfg_pkg::VRF_WORD_W-1:0] vrf_rdata_i,
  vfu_issue_if.slave                              issue,
  vfu_lane_if.source                              lane
);
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  logic            valid_q;
  vfu_op_e         op_q;
  vew_e            vsew_q;
  logic            use_vs1_q;
  logic [ELEN-1:0] rs1_q;
  vfu_tag_t        tag_q;
  lane_word_u      scalar;

  // Read data arrives one cycle after issue
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue.valid) begin
      op_q      <= issue.op;
      vsew_q    <= issue.vsew;
      use_vs1_q <= issue.use_vs1;
      rs1_q     <= issue.rs1;
      tag_q     <= issue.tag;
    end
  end

  // Truncate rs1 and fill one lane word
  always_comb begin
    scalar.w = rs1_q;
    unique case (vsew_q)
      EW_8:    scalar.b = {ELENB{rs1_q[7:0]}};
      EW_16:   scalar.h = {(ELENB/2){rs1_q[15:0]}};
      default: ;
    endcase
  end

  assign lane.valid = valid_q;
  assign lane.op    = op_q;
  assign lane.vsew  = vsew_q;
  assign lane.tag   = tag_q;
  assign lane.op2   = vrf_rdata_i[0];
  assign lane.op1   = use_vs1_q ? vrf_rdata_i[1] : {N_LANES{scalar.w}};

endmodule : vfu_operand_stage

//--- verilog/vfu_lane.sv
/*
 * One SIMD integer lane, two register stages
 * ADD, SUB, AND, OR, XOR on 8, 16 or 32 bit elements
 */

`timescale 1ns/1ps

module vfu_lane #(
  parameter int unsigned LANE = 0
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  vfu_lane_if.lane lane
);
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  logic       valid_s1;
  logic       valid_s2;
  vfu_op_e    op_s1;
  vew_e       vsew_s1;
  lane_word_u a_s1;
  lane_word_u b_s1;
  lane_word_u res_d;
  lane_word_u res_s2;

  // Operands zero-extended, caller truncates to the element
  function automatic logic [ELEN-1:0] alu(vfu_op_e op, logic [ELEN-1:0] x, logic [ELEN-1:0] y);
    unique case (op)
      VADD:    return x + y;
      VSUB:    return x - y;
      VAND:    return x & y;
      VOR:     return x | y;
      default: return x ^ y;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= lane.valid;
      valid_s2 <= valid_s1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane.valid) begin
      op_s1   <= lane.op;
      vsew_s1 <= lane.vsew;
      a_s1    <= lane.op2[LANE*ELEN +: ELEN];
      b_s1    <= lane.op1[LANE*ELEN +: ELEN];
    end
    if (valid_s1) begin
      res_s2 <= res_d;
    end
  end

  // Each element on its own, no carry across element borders
  always_comb begin
    res_d.w = alu(op_s1, a_s1.w, b_s1.w);
    unique case (vsew_s1)
      EW_8: begin
        for (int i = 0; i < ELENB; i++) begin
          res_d.b[i] = 8'(alu(op_s1, ELEN'(a_s1.b[i]), ELEN'(b_s1.b[i])));
        end
      end
      EW_16: begin
        for (int i = 0; i < ELENB / 2; i++) begin
          res_d.h[i] = 16'(alu(op_s1, ELEN'(a_s1.h[i]), ELEN'(b_s1.h[i])));
        end
      end
      default: ;
    endcase
  end

  assign lane.result[LANE*ELEN +: ELEN] = res_s2;
  assign lane.res_valid[LANE]           = valid_s2;

  // Only lane 0 carries the tag
  if (LANE == 0) begin : g_tag
    vfu_tag_t tag_s1;
    vfu_tag_t tag_s2;

    always_ff @(posedge clk_i) begin
      tag_s1 <= lane.tag;
      tag_s2 <= tag_s1;
    end

    assign lane.res_tag = tag_s2;
  end

endmodule : vfu_lane

//--- verilog/vfu_writeback.sv
/*
 * Register-file write and completion response
 */

`timescale 1ns/1ps

module vfu_writeback (
  vfu_lane_if.sink                              lane,
  output logic [vfu_cfg_pkg::VREG_ADDR_W-1:0]   vrf_waddr_o,
  output logic [vfu_cfg_pkg::VRF_WORD_W-1:0]    vrf_wdata_o,
  output logic                                  vrf_we_o,
  output logic [vfu_cfg_pkg::VRF_BE_W-1:0]      vrf_wbe_o,
  output logic                                  rsp_valid_o,
  output logic [vfu_cfg_pkg::ID_W-1:0]          rsp_id_o
);

  // Write once every lane holds its result
  assign vrf_we_o    = &lane.res_valid;
  assign vrf_wdata_o = lane.result;
  assign vrf_waddr_o = lane.res_tag.vd_addr;
  assign vrf_wbe_o   = lane.res_tag.be;

  // Instruction done with its last word
  assign rsp_valid_o = vrf_we_o && lane.res_tag.last;
  assign rsp_id_o    = lane.res_tag.id;

endmodule : vfu_writeback

//--- verilog/vfu_top.sv
/*
 * Vector functional unit top level
 * Request queue, sequencer, operand stage, lanes and write-back
 */

`timescale 1ns/1ps

module vfu_top (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  input  logic [vfu_cfg_pkg::ID_W-1:0]             req_id_i,
  input  vfu_isa_pkg::vfu_op_e                     req_op_i,
  input  vfu_isa_pkg::vew_e                        req_vsew_i,
  input  logic [vfu_cfg_pkg::VL_W-1:0]             req_vl_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]       req_vs1_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]       req_vs2_i,
  input  logic [vfu_cfg_pkg::VREG_IDX_W-1:0]       req_vd_i,
  input  logic                                     req_use_vs1_i,
  input  logic [vfu_cfg_pkg::ELEN-1:0]             req_rs1_i,
  output logic [1:0][vfu_cfg_pkg::VREG_ADDR_W-1:0] vrf_raddr_o,
  output logic [1:0]                               vrf_re_o,
  input  logic [1:0][vfu_cfg_pkg::VRF_WORD_W-1:0]  vrf_rdata_i,
  output logic [vfu_cfg_pkg::VREG_ADDR_W-1:0]      vrf_waddr_o,
  output logic [vfu_cfg_pkg::VRF_WORD_W-1:0]       vrf_wdata_o,
  output logic                                     vrf_we_o,
  output logic [vfu_cfg_pkg::VRF_BE_W-1:0]         vrf_wbe_o,
  output logic                                     rsp_valid_o,
  output logic [vfu_cfg_pkg::ID_W-1:0]             rsp_id_o
);
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  // Queue head
  logic                  deq_valid;
  logic                  deq;
  logic [ID_W-1:0]       deq_id;
  vfu_op_e               deq_op;
  vew_e                  deq_vsew;
  logic [VL_W-1:0]       deq_vl;
  logic [VREG_IDX_W-1:0] deq_vs1;
  logic [VREG_IDX_W-1:0] deq_vs2;
  logic [VREG_IDX_W-1:0] deq_vd;
  logic                  deq_use_vs1;
  logic [ELEN-1:0]       deq_rs1;

  vfu_issue_if issue_if ();
  vfu_lane_if  lane_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Front end

  vfu_op_queue op_queue_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_id_i      (req_id_i),
    .req_op_i      (req_op_i),
    .req_vsew_i    (req_vsew_i),
    .req_vl_i      (req_vl_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_vd_i      (req_vd_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_rs1_i     (req_rs1_i),
    .deq_valid_o   (deq_valid),
    .deq_i         (deq),
    .deq_id_o      (deq_id),
    .deq_op_o      (deq_op),
    .deq_vsew_o    (deq_vsew),
    .deq_vl_o      (deq_vl),
    .deq_vs1_o     (deq_vs1),
    .deq_vs2_o     (deq_vs2),
    .deq_vd_o      (deq_vd),
    .deq_use_vs1_o (deq_use_vs1),
    .deq_rs1_o     (deq_rs1)
  );

  vfu_sequencer sequencer_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .deq_valid_i   (deq_valid),
    .deq_o         (deq),
    .deq_id_i      (deq_id),
    .deq_op_i      (deq_op),
    .deq_vsew_i    (deq_vsew),
    .deq_vl_i      (deq_vl),
    .deq_vs1_i     (deq_vs1),
    .deq_vs2_i     (deq_vs2),
    .deq_vd_i      (deq_vd),
    .deq_use_vs1_i (deq_use_vs1),
    .deq_rs1_i     (deq_rs1),
    .vrf_raddr_o   (vrf_raddr_o),
    .vrf_re_o      (vrf_re_o),
    .issue         (issue_if.master)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath

  vfu_operand_stage operand_stage_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .vrf_rdata_i (vrf_rdata_i),
    .issue       (issue_if.slave),
    .lane        (lane_if.source)
  );

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    vfu_lane #(
      .LANE (l)
    ) lane_inst (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .lane     (lane_if.lane)
    );
  end

  vfu_writeback writeback_inst (
    .lane        (lane_if.sink),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_id_o    (rsp_id_o)
  );

endmodule : vfu_top

//--- dv/vfu_asserts.sv
/*
 * Timing assertions on the vector functional unit top level
 * Read to write latency and response only with a write
 */

`timescale 1ns/1ps

module vfu_asserts (
  input logic clk_i,
  input logic arst_n_i,
  input logic vrf_re_i,
  input logic vrf_we_i,
  input logic rsp_valid_i
);

  // Count of failed assertions
  int fail_count = 0;

  // Every write belongs to a read three cycles earlier
  we_after_re: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) vrf_we_i |-> $past(vrf_re_i, 3)
  ) else begin
    $error("vrf_we_o without a vrf_re_o three cycles earlier");
    fail_count++;
  end

  // And every read produces its write
  re_then_we: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) vrf_re_i |-> ##3 vrf_we_i
  ) else begin
    $error("vrf_re_o not followed by vrf_we_o three cycles later");
    fail_count++;
  end

  // Response rides on the last write
  rsp_with_we: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) rsp_valid_i |-> vrf_we_i
  ) else begin
    $error("rsp_valid_o high without vrf_we_o");
    fail_count++;
  end

endmodule : vfu_asserts

bind vfu_top vfu_asserts vfu_asserts_inst (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .vrf_re_i    (vrf_re_o[0]),
  .vrf_we_i    (vrf_we_o),
  .rsp_valid_i (rsp_valid_o)
);

//--- dv/vfu_tb.sv
/*
 * Testbench of the vector functional unit
 * Clock, reset, register-file model, scoreboard, directed tests, report
 */

`timescale 1ns/1ps

module vfu_tb;
  import vfu_cfg_pkg::*;
  import vfu_isa_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int TEST_CYCLES = 200;
  localparam int N_TESTS     = 5;
  localparam int VRF_WORDS   = 128;

  // One expected register-file write
  typedef struct {
    logic [VREG_ADDR_W-1:0] addr;
    logic [VRF_WORD_W-1:0]  data;
    logic [VRF_BE_W-1:0]    be;
    logic                   last;
    logic [ID_W-1:0]        id;
  } wr_exp_t;

  logic                              clk;
  logic                              arst_n;
  logic                              req_valid;
  logic                              req_ready;
  logic [ID_W-1:0]                   req_id;
  vfu_op_e                           req_op;
  vew_e                              req_vsew;
  logic [VL_W-1:0]                   req_vl;
  logic [VREG_IDX_W-1:0]             req_vs1;
  logic [VREG_IDX_W-1:0]             req_vs2;
  logic [VREG_IDX_W-1:0]             req_vd;
  logic                              req_use_vs1;
  logic [ELEN-1:0]                   req_rs1;
  logic [1:0][VREG_ADDR_W-1:0]       vrf_raddr;
  logic [1:0]                        vrf_re;
  logic [1:0][VRF_WORD_W-1:0]        vrf_rdata;
  logic [VREG_ADDR_W-1:0]            vrf_waddr;
  logic [VRF_WORD_W-1:0]             vrf_wdata;
  logic                              vrf_we;
  logic [VRF_BE_W-1:0]               vrf_wbe;
  logic                              rsp_valid;
  logic [ID_W-1:0]                   rsp_id;

  wr_exp_t               sb[$];
  logic [VRF_WORD_W-1:0] mem [VRF_WORDS];
  logic [31:0]           lfsr_state;
  int                    errors;
  int                    test_errors;
  int                    checks;
  int                    tests_run;
  int                    tests_failed;
  int                    rsp_count;
  int                    assert_fails_seen;
  logic                  ready_low_seen;

  vfu_top vfu_top_inst (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_id_i      (req_id),
    .req_op_i      (req_op),
    .req_vsew_i    (req_vsew),
    .req_vl_i      (req_vl),
    .req_vs1_i     (req_vs1),
    .req_vs2_i     (req_vs2),
    .req_vd_i      (req_vd),
    .req_use_vs1_i (req_use_vs1),
    .req_rs1_i     (req_rs1),
    .vrf_raddr_o   (vrf_raddr),
    .vrf_re_o      (vrf_re),
    .vrf_rdata_i   (vrf_rdata),
    .vrf_waddr_o   (vrf_waddr),
    .vrf_wdata_o   (vrf_wdata),
    .vrf_we_o      (vrf_we),
    .vrf_wbe_o     (vrf_wbe),
    .rsp_valid_o   (rsp_valid),
    .rsp_id_o      (rsp_id)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference helpers

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = b ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    return b;
  endfunction

  function automatic logic [63:0] rand_word(input int nbits);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[62:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Element-wise result, vs2 op vs1, wrapping inside each element
  function automatic logic [VRF_WORD_W-1:0] ref_word(input vfu_op_e op, input int ebits,
                                                     input logic [VRF_WORD_W-1:0] a,
                                                     input logic [VRF_WORD_W-1:0] b);
    logic [VRF_WORD_W-1:0] r;
    logic [31:0]           mask;
    logic [31:0]           ea;
    logic [31:0]           eb;
    logic [31:0]           er;
    r    = '0;
    mask = (ebits == 32) ? 32'hffff_ffff : (32'h1 << ebits) - 32'h1;
    for (int e = 0; e < VRF_WORD_W / ebits; e++) begin
      ea = 32'(a >> (e * ebits)) & mask;
      eb = 32'(b >> (e * ebits)) & mask;
      case (op)
        VADD:    er = ea + eb;
        VSUB:    er = ea - eb;
        VAND:    er = ea & eb;
        VOR:     er = ea | eb;
        default: er = ea ^ eb;
      endcase
      r |= VRF_WORD_W'(er & mask) << (e * ebits);
    end
    return r;
  endfunction

  // Scalar cut to one element and copied into every slot
  function automatic logic [VRF_WORD_W-1:0] splat(input logic [31:0] rs1, input int ebits);
    logic [VRF_WORD_W-1:0] r;
    logic [31:0]           mask;
    r    = '0;
    mask = (ebits == 32) ? 32'hffff_ffff : (32'h1 << ebits) - 32'h1;
    for (int e = 0; e < VRF_WORD_W / ebits; e++) begin
      r |= VRF_WORD_W'(rs1 & mask) << (e * ebits);
    end
    return r;
  endfunction

  function automatic logic [VRF_WORD_W-1:0] byte_mask(input logic [VRF_BE_W-1:0] be);
    logic [VRF_WORD_W-1:0] m;
    for (int i = 0; i < VRF_BE_W; i++) begin
      m[i*8 +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  task automatic check_value(input string sig, input logic [63:0] got,
                             input logic [63:0] want);
    checks++;
    assert (got === want) else begin
      $display("FAIL %0t %s expected %0h got %0h", $time, sig, want, got);
      test_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Register-file model and write monitor

  // Read strobe seen in one cycle, data driven in the next
  always begin : vrf_read_model
    logic [1:0]                  re_s;
    logic [1:0][VREG_ADDR_W-1:0] addr_s;
    @(negedge clk);
    re_s   = vrf_re;
    addr_s = vrf_raddr;
    @(posedge clk);
    #1;
    for (int p = 0; p < 2; p++) begin
      if (re_s[p]) begin
        vrf_rdata[p] = mem[addr_s[p]];
      end
    end
  end

  always @(negedge clk) begin : write_monitor
    wr_exp_t e_wr;
    if (arst_n && !req_ready) begin
      ready_low_seen = 1'b1;
    end
    if (rsp_valid) begin
      rsp_count++;
    end
    if (vrf_we) begin
      if (sb.size() == 0) begin
        $display("Write to word %0d arrived with no instruction outstanding", vrf_waddr);
        test_errors++;
      end else begin
        e_wr = sb.pop_front();
        check_value("vrf_waddr_o", vrf_waddr, e_wr.addr);
        check_value("vrf_wbe_o", vrf_wbe, e_wr.be);
        check_value("vrf_wdata_o", vrf_wdata & byte_mask(e_wr.be),
                    e_wr.data & byte_mask(e_wr.be));
        check_value("rsp_valid_o", rsp_valid, e_wr.last);
        if (e_wr.last) begin
          check_value("rsp_id_o", rsp_id, e_wr.id);
        end
      end
      for (int i = 0; i < VRF_BE_W; i++) begin
        if (vrf_wbe[i]) begin
          mem[vrf_waddr][i*8 +: 8] = vrf_wdata[i*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, entered and left 1 ns after a rising edge

  task automatic send(input logic [ID_W-1:0] id, input vfu_op_e op, input vew_e ew,
                      input int vl, input int vs1, input int vs2, input int vd,
                      input logic use_vs1, input logic [31:0] rs1);
    int                    ebits;
    int                    epw;
    int                    nwords;
    int                    live;
    logic [VRF_WORD_W-1:0] opb;
    wr_exp_t               e_wr;
    ebits  = 8 << int'(ew);
    epw    = VRF_WORD_W / ebits;
    nwords = (vl + epw - 1) / epw;
    for (int w = 0; w < nwords; w++) begin
      live      = (vl - w * epw < epw) ? vl - w * epw : epw;
      opb       = use_vs1 ? mem[vs1 * WORDS_PER_VREG + w] : splat(rs1, ebits);
      e_wr.addr = VREG_ADDR_W'(vd * WORDS_PER_VREG + w);
      e_wr.data = ref_word(op, ebits, mem[vs2 * WORDS_PER_VREG + w], opb);
      e_wr.be   = VRF_BE_W'((16'h1 << (live * ebits / 8)) - 16'h1);
      e_wr.last = (w == nwords - 1);
      e_wr.id   = id;
      sb.push_back(e_wr);
    end
    req_valid   = 1'b1;
    req_id      = id;
    req_op      = op;
    req_vsew    = ew;
    req_vl      = VL_W'(vl);
    req_vs1     = VREG_IDX_W'(vs1);
    req_vs2     = VREG_IDX_W'(vs2);
    req_vd      = VREG_IDX_W'(vd);
    req_use_vs1 = use_vs1;
    req_rs1     = rs1;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (sb.size() != 0 && n < TEST_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (sb.size() != 0) begin
      $display("Test %s still waits for %0d writes after %0d cycles", name, sb.size(), n);
      test_errors++;
    end
    // Idle tail so late strobes show up in this test
    repeat (4) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("req_ready_o", req_ready, 1);
      check_value("vrf_re_o", vrf_re, 0);
      check_value("vrf_we_o", vrf_we, 0);
      check_value("rsp_valid_o", rsp_valid, 0);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    int new_fails;
    new_fails         = vfu_top_inst.vfu_asserts_inst.fail_count - assert_fails_seen;
    assert_fails_seen = vfu_top_inst.vfu_asserts_inst.fail_count;
    if (new_fails != 0) begin
      $display("Test %s tripped %0d bound timing assertions", name, new_fails);
      test_errors += new_fails;
    end
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %-12s passed", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, test_errors);
    end
    test_errors    = 0;
    rsp_count      = 0;
    ready_low_seen = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    clk               = 1'b0;
    arst_n            = 1'b0;
    req_valid         = 1'b0;
    req_id            = '0;
    req_op            = VADD;
    req_vsew          = EW_8;
    req_vl            = '0;
    req_vs1           = '0;
    req_vs2           = '0;
    req_vd            = '0;
    req_use_vs1       = 1'b0;
    req_rs1           = '0;
    vrf_rdata         = '0;
    errors            = 0;
    test_errors       = 0;
    checks            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    rsp_count         = 0;
    assert_fails_seen = 0;
    ready_low_seen    = 1'b0;
    lfsr_state        = 32'd46;
    for (int i = 0; i < VRF_WORDS; i++) begin
      mem[i] = rand_word(VRF_WORD_W);
    end

    repeat (5) begin
      @(posedge clk);
    end
    #1;
    arst_n = 1'b1;

    check_idle(10);
    finish_test("reset_idle");

    // Sources live in registers 0..15, results in 16 and up
    send(0, VADD, EW_8, 32, 1, 2, 16, 1'b1, 32'h0);
    send(1, VSUB, EW_8, 32, 3, 4, 17, 1'b1, 32'h0);
    send(2, VADD, EW_16, 16, 5, 6, 18, 1'b1, 32'h0);
    send(3, VSUB, EW_16, 16, 7, 8, 19, 1'b1, 32'h0);
    send(0, VADD, EW_32, 8, 9, 10, 20, 1'b1, 32'h0);
    send(1, VSUB, EW_32, 8, 11, 12, 21, 1'b1, 32'h0);
    wait_drain("vv_add_sub");
    finish_test("vv_add_sub");

    send(2, VAND, EW_8, 32, 0, 13, 22, 1'b0, 32'(rand_word(32)));
    send(3, VOR, EW_16, 16, 0, 14, 23, 1'b0, 32'(rand_word(32)));
    send(0, VXOR, EW_32, 8, 0, 15, 24, 1'b0, 32'(rand_word(32)));
    wait_drain("vs_logic");
    finish_test("vs_logic");

    // Last word only partly live at every width
    send(1, VADD, EW_8, 13, 1, 2, 25, 1'b1, 32'h0);
    send(2, VXOR, EW_16, 5, 0, 3, 26, 1'b0, 32'(rand_word(32)));
    send(3, VSUB, EW_32, 3, 4, 5, 27, 1'b1, 32'h0);
    wait_drain("partial_vl");
    check_value("rsp_valid_o pulses", rsp_count, 3);
    finish_test("partial_vl");

    send(3, VADD, EW_16, 16, 6, 7, 28, 1'b1, 32'h0);
    send(0, VSUB, EW_16, 16, 8, 9, 29, 1'b1, 32'h0);
    send(1, VXOR, EW_16, 16, 10, 11, 30, 1'b1, 32'h0);
    wait_drain("back2back");
    check_value("req_ready_o low seen", ready_low_seen, 1);
    check_value("rsp_valid_o pulses", rsp_count, 3);
    finish_test("back2back");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the per-test budget
  initial begin
    #(CLK_PERIOD * (TEST_CYCLES * N_TESTS + 20));
    $display("Watchdog expired before the test sequence completed");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule : vfu_tb

//--- build.f
verilog/vfu_cfg_pkg.sv
verilog/vfu_isa_pkg.sv
verilog/vfu_if.sv
verilog/vfu_op_queue.sv
verilog/vfu_sequencer.sv
verilog/vfu_operand_stage.sv
verilog/vfu_lane.sv
verilog/vfu_writeback.sv
verilog/vfu_top.sv
dv/vfu_asserts.sv
dv/vfu_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module vfu_tb \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vvfu_tb)"
echo "$out"

echo "$out" | grep -qx "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }
